/* tb.f */
+incdir+.
heapPkg.sv
heapAllocator.sv
heapSizeTable.sv
heapElementStore.sv
heapController.sv
heapUnit.sv
heapUnitChecker.sv
heapUnitTb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert -f tb.f --top-module heapUnitTb -Mdir obj_dir -o heapUnitSim
	./obj_dir/heapUnitSim | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* heapTests.svh */
// Heap unit command table
// One row per cycle, with the result expected on the following done
`ifndef HEAP_TESTS_SVH
`define HEAP_TESTS_SVH

// Columns are start, action, array, index, in, expected out, expected error
task automatic loadTable();
  // --------------------
  // Allocation from reset, exhaustion and Clear
  addRow(1'b1, CmdAlloc, 2'd0, 2'd0, 12'h000, 12'h000, ErrNone);
  addRow(1'b1, CmdAlloc, 2'd0, 2'd0, 12'h000, 12'h001, ErrNone);
  addRow(1'b1, CmdAlloc, 2'd0, 2'd0, 12'h000, 12'h002, ErrNone);
  addRow(1'b1, CmdAlloc, 2'd0, 2'd0, 12'h000, 12'h003, ErrNone);
  addRow(1'b1, CmdAlloc, 2'd0, 2'd0, 12'h000, 12'h000, ErrNoMemory);
  addRow(1'b1, CmdClear, 2'd0, 2'd0, 12'h000, 12'h000, ErrNone);
  addRow(1'b1, CmdAlloc, 2'd0, 2'd0, 12'h000, 12'h000, ErrNone);
  // --------------------
  // Write growth, Size and Read bounds on array 0
  addRow(1'b1, CmdWrite, 2'd0, 2'd2, 12'h123, 12'h123, ErrNone);
  addRow(1'b1, CmdSize,  2'd0, 2'd0, 12'h000, 12'h003, ErrNone);   // Grew to index+1
  addRow(1'b1, CmdRead,  2'd0, 2'd2, 12'h000, 12'h123, ErrNone);
  addRow(1'b1, CmdRead,  2'd0, 2'd3, 12'h000, 12'h000, ErrOutOfBounds);
  addRow(1'b1, CmdWrite, 2'd0, 2'd0, 12'h456, 12'h456, ErrNone);
  addRow(1'b0, CmdRead,  2'd0, 2'd0, 12'h000, 12'h000, ErrNone);   // Idle, no done
  // --------------------
  // Push until full, then Pop until empty, on array 1
  addRow(1'b1, CmdAlloc, 2'd0, 2'd0, 12'h000, 12'h001, ErrNone);
  addRow(1'b1, CmdPush,  2'd1, 2'd0, 12'h011, 12'h000, ErrNone);
  addRow(1'b1, CmdPush,  2'd1, 2'd0, 12'h022, 12'h000, ErrNone);
  addRow(1'b1, CmdPush,  2'd1, 2'd0, 12'h033, 12'h000, ErrNone);
  addRow(1'b1, CmdPush,  2'd1, 2'd0, 12'h044, 12'h000, ErrNone);
  addRow(1'b1, CmdPush,  2'd1, 2'd0, 12'h055, 12'h000, ErrFull);
  addRow(1'b1, CmdSize,  2'd1, 2'd0, 12'h000, 12'h004, ErrNone);
  addRow(1'b1, CmdPop,   2'd1, 2'd0, 12'h000, 12'h044, ErrNone);
  addRow(1'b1, CmdPop,   2'd1, 2'd0, 12'h000, 12'h033, ErrNone);
  addRow(1'b1, CmdPop,   2'd1, 2'd0, 12'h000, 12'h022, ErrNone);
  addRow(1'b1, CmdPop,   2'd1, 2'd0, 12'h000, 12'h011, ErrNone);
  addRow(1'b1, CmdPop,   2'd1, 2'd0, 12'h000, 12'h000, ErrEmpty);
  // --------------------
  // Read-modify-write chain on array 0 index 1
  addRow(1'b1, CmdWrite,    2'd0, 2'd1, 12'h0A5, 12'h0A5, ErrNone);
  addRow(1'b1, CmdAddAfter, 2'd0, 2'd1, 12'h00F, 12'h0A5, ErrNone);  // Now 0B4
  addRow(1'b1, CmdSubAfter, 2'd0, 2'd1, 12'h00F, 12'h0B4, ErrNone);  // Back to 0A5
  addRow(1'b1, CmdAdd,      2'd0, 2'd1, 12'h00F, 12'h0B4, ErrNone);
  addRow(1'b1, CmdSub,      2'd0, 2'd1, 12'h00F, 12'h0A5, ErrNone);
  addRow(1'b1, CmdOr,       2'd0, 2'd1, 12'h00F, 12'h0AF, ErrNone);
  addRow(1'b1, CmdWrite,    2'd0, 2'd1, 12'h0A5, 12'h0A5, ErrNone);
  addRow(1'b1, CmdXor,      2'd0, 2'd1, 12'h00F, 12'h0AA, ErrNone);
  addRow(1'b1, CmdWrite,    2'd0, 2'd1, 12'h0A5, 12'h0A5, ErrNone);
  addRow(1'b1, CmdAnd,      2'd0, 2'd1, 12'h00F, 12'h005, ErrNone);
  addRow(1'b1, CmdWrite,    2'd0, 2'd1, 12'h0A5, 12'h0A5, ErrNone);
  addRow(1'b1, CmdNot,      2'd0, 2'd1, 12'h00F, 12'hF5A, ErrNone);
  // --------------------
  // Free, LIFO reuse and command errors
  addRow(1'b1, CmdAlloc, 2'd0, 2'd0, 12'h000, 12'h002, ErrNone);
  addRow(1'b1, CmdAlloc, 2'd0, 2'd0, 12'h000, 12'h003, ErrNone);
  addRow(1'b1, CmdPush,  2'd3, 2'd0, 12'h077, 12'h000, ErrNone);          // Size 1 before free
  addRow(1'b1, CmdFree,  2'd1, 2'd0, 12'h000, 12'h000, ErrNone);
  addRow(1'b1, CmdFree,  2'd3, 2'd0, 12'h000, 12'h000, ErrNone);
  addRow(1'b1, CmdRead,  2'd3, 2'd0, 12'h000, 12'h000, ErrNotAllocated);
  addRow(1'b1, CmdSize,  2'd1, 2'd0, 12'h000, 12'h000, ErrNotAllocated);
  addRow(1'b1, CmdFree,  2'd1, 2'd0, 12'h000, 12'h000, ErrNotAllocated);  // Double free
  addRow(1'b1, CmdAlloc, 2'd0, 2'd0, 12'h000, 12'h003, ErrNone);          // Last freed first
  addRow(1'b1, CmdAlloc, 2'd0, 2'd0, 12'h000, 12'h001, ErrNone);
  addRow(1'b1, CmdSize,  2'd3, 2'd0, 12'h000, 12'h000, ErrNone);          // Reused starts empty
  addRow(1'b1, CmdAlloc, 2'd0, 2'd0, 12'h000, 12'h000, ErrNoMemory);
  addRow(1'b1, 5'd0,     2'd0, 2'd0, 12'h000, 12'h000, ErrBadCommand);
  addRow(1'b1, 5'd31,    2'd0, 2'd0, 12'h000, 12'h000, ErrBadCommand);
endtask

`endif

/* heapUnitTb.sv */
// Heap unit testbench
// Applies the command table one row per cycle and hands each row's
// expected result to the checker
module heapUnitTb;
  timeunit 1ns;
  timeprecision 100ps;
  import heapPkg::*;

  logic                  clock;
  logic                  resetN;
  logic                  start;
  logic [ActionBits-1:0] action;
  logic [ArrayBits-1:0]  array;
  logic [IndexBits-1:0]  index;
  logic [DataWidth-1:0]  in;
  logic [DataWidth-1:0]  out;
  logic [ErrorBits-1:0]  error;
  logic                  done;
  logic                  expValid;
  logic [DataWidth-1:0]  expOut;
  logic [ErrorBits-1:0]  expError;
  int                    valueErrors;
  int                    protocolErrors;
  int                    cycles = 0;
  int                    cycleLimit;

  // Table columns
  logic                  rowStart [$];
  logic [ActionBits-1:0] rowAction [$];
  logic [ArrayBits-1:0]  rowArray [$];
  logic [IndexBits-1:0]  rowIndex [$];
  logic [DataWidth-1:0]  rowIn [$];
  logic [DataWidth-1:0]  rowOut [$];
  logic [ErrorBits-1:0]  rowError [$];

  task automatic addRow(input logic s, input logic [ActionBits-1:0] a,
                        input logic [ArrayBits-1:0] arr, input logic [IndexBits-1:0] idx,
                        input logic [DataWidth-1:0] d, input logic [DataWidth-1:0] eo,
                        input logic [ErrorBits-1:0] ee);
    rowStart.push_back(s);
    rowAction.push_back(a);
    rowArray.push_back(arr);
    rowIndex.push_back(idx);
    rowIn.push_back(d);
    rowOut.push_back(eo);
    rowError.push_back(ee);
  endtask

  `include "heapTests.svh"

  heapUnit dut_i (
    .clock, .resetN, .start, .action, .array, .index, .in, .out, .error, .done
  );

  heapUnitChecker checker_i (
    .clock, .resetN, .done, .out, .error, .expValid, .expOut, .expError,
    .valueErrors, .protocolErrors
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;                    // 4 ns period
  end

  // --------------------
  // Timeout
  always @(posedge clock) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("Run stopped after %0d cycles without finishing", cycleLimit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // --------------------
  // Stimulus
  initial begin
    resetN   = 1'b0;
    start    = 1'b0;
    action   = '0;
    array    = '0;
    index    = '0;
    in       = '0;
    expValid = 1'b0;
    expOut   = '0;
    expError = ErrNone;
    loadTable();
    cycleLimit = rowStart.size() + 10 + 20;
    repeat (10) @(posedge clock);
    #1 resetN = 1'b1;
    for (int r = 0; r < rowStart.size(); r++) begin
      @(posedge clock);
      #1;
      start    = rowStart[r];
      action   = rowAction[r];
      array    = rowArray[r];
      index    = rowIndex[r];
      in       = rowIn[r];
      expValid = rowStart[r];
      expOut   = rowOut[r];
      expError = rowError[r];
    end
    @(posedge clock);
    #1;
    start    = 1'b0;
    expValid = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock);                             // Last result compared
    $display("Value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
    if (valueErrors == 0 && protocolErrors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* heapUnitChecker.sv */
// Heap unit result checker
// Lines each expectation up with its command and compares out and error
// when done arrives, flagging missing or unexpected done pulses
module heapUnitChecker (
  input  logic                          clock,
  input  logic                          resetN,
  input  logic                          done,
  input  logic [heapPkg::DataWidth-1:0] out,
  input  logic [heapPkg::ErrorBits-1:0] error,
  input  logic                          expValid,
  input  logic [heapPkg::DataWidth-1:0] expOut,
  input  logic [heapPkg::ErrorBits-1:0] expError,
  output int                            valueErrors,
  output int                            protocolErrors
);
  timeunit 1ns;
  timeprecision 100ps;
  import heapPkg::*;

  logic                 pending;                  // A result is due now
  logic [DataWidth-1:0] pendingOut;
  logic [ErrorBits-1:0] pendingError;

  // Expectation moves along with the command the DUT samples
  always @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      pending      <= 1'b0;
      pendingOut   <= '0;
      pendingError <= ErrNone;
    end else begin
      pending      <= expValid;
      pendingOut   <= expOut;
      pendingError <= expError;
    end
  end

  // --------------------
  // Compare mid-cycle, away from the clock edge
  always @(negedge clock) begin
    if (!resetN) begin
      valueErrors    = 0;
      protocolErrors = 0;
    end else if (pending && !done) begin
      $display("Command at %0t ns got no done pulse", $time);
      protocolErrors++;
    end else if (!pending && done) begin
      $display("Done pulse at %0t ns without a command", $time);
      protocolErrors++;
    end else if (pending) begin
      if (out !== pendingOut) begin
        $display("[ERROR] out: got 0x%03h, expected 0x%03h", out, pendingOut);
        valueErrors++;
      end
      if (error !== pendingError) begin
        $display("[ERROR] error: got 0x%0h, expected 0x%0h", error, pendingError);
        valueErrors++;
      end
    end
  end

endmodule

/* heapUnit.sv */
// Heap array memory unit
// Takes one command per start strobe and returns out, error and done on
// the following clock edge
module heapUnit (
  input  logic                           clock,
  input  logic                           resetN,
  input  logic                           start,
  input  logic [heapPkg::ActionBits-1:0] action,
  input  logic [heapPkg::ArrayBits-1:0]  array,
  input  logic [heapPkg::IndexBits-1:0]  index,
  input  logic [heapPkg::DataWidth-1:0]  in,
  output logic [heapPkg::DataWidth-1:0]  out,
  output logic [heapPkg::ErrorBits-1:0]  error,
  output logic                           done
);
  import heapPkg::*;

  // --------------------
  // Internal nets
  // --------------------
  logic                 clearEnable;
  logic                 allocEnable;
  logic                 freeEnable;
  logic                 arrayLive;
  logic                 canAlloc;
  logic [ArrayBits-1:0] allocArray;
  logic                 sizeLoad;
  logic [ArrayBits-1:0] sizeArray;
  logic [SizeBits-1:0]  newSize;
  logic [SizeBits-1:0]  currentSize;
  logic                 storeWrite;
  logic [IndexBits-1:0] elementIndex;
  logic [DataWidth-1:0] readData;
  logic [DataWidth-1:0] newData;

  heapAllocator allocator_i (
    .clock, .resetN, .clearEnable, .allocEnable, .freeEnable,
    .array, .arrayLive, .canAlloc, .allocArray
  );

  heapSizeTable sizeTable_i (
    .clock, .resetN, .array, .sizeLoad, .sizeArray, .newSize, .currentSize
  );

  heapElementStore elementStore_i (
    .clock, .action, .array, .elementIndex, .in, .storeWrite, .readData, .newData
  );

  heapController controller_i (
    .clock, .resetN, .start, .action, .array, .index, .in,
    .arrayLive, .canAlloc, .allocArray, .currentSize, .readData, .newData,
    .clearEnable, .allocEnable, .freeEnable, .sizeLoad, .sizeArray, .newSize,
    .storeWrite, .elementIndex, .out, .error, .done
  );

endmodule

/* heapController.sv */
// Heap unit controller
// Decodes one command per start strobe, checks it against the allocation
// and size state, drives the block enables and registers the result
module heapController (
  input  logic                           clock,
  input  logic                           resetN,
  input  logic                           start,
  input  logic [heapPkg::ActionBits-1:0] action,
  input  logic [heapPkg::ArrayBits-1:0]  array,
  input  logic [heapPkg::IndexBits-1:0]  index,
  input  logic [heapPkg::DataWidth-1:0]  in,
  input  logic                           arrayLive,
  input  logic                           canAlloc,
  input  logic [heapPkg::ArrayBits-1:0]  allocArray,
  input  logic [heapPkg::SizeBits-1:0]   currentSize,
  input  logic [heapPkg::DataWidth-1:0]  readData,
  input  logic [heapPkg::DataWidth-1:0]  newData,
  output logic                           clearEnable,
  output logic                           allocEnable,
  output logic                           freeEnable,
  output logic                           sizeLoad,
  output logic [heapPkg::ArrayBits-1:0]  sizeArray,
  output logic [heapPkg::SizeBits-1:0]   newSize,
  output logic                           storeWrite,
  output logic [heapPkg::IndexBits-1:0]  elementIndex,
  output logic [heapPkg::DataWidth-1:0]  out,
  output logic [heapPkg::ErrorBits-1:0]  error,
  output logic                           done
);
  import heapPkg::*;

  logic [SizeBits-1:0]  indexSize;                // Index widened for compares
  logic [IndexBits-1:0] lastIndex;                // Top element, for Pop
  logic                 inBounds;
  logic                 knownCmd;
  logic                 needsLive;                // All but Clear and Alloc
  logic                 isAfter;                  // Returns the old value
  logic                 accept;
  logic [ErrorBits-1:0] cmdError;
  logic [DataWidth-1:0] result;
  logic                 doClear;
  logic                 doAlloc;
  logic                 doFree;
  logic                 doSize;
  logic                 doStore;

  assign indexSize = {1'b0, index};
  assign lastIndex = currentSize[IndexBits-1:0] - 1'b1;
  assign inBounds  = indexSize < currentSize;
  assign knownCmd  = (action >= CmdClear) && (action <= CmdNot);
  assign needsLive = (action != CmdClear) && (action != CmdAlloc);
  assign isAfter   = (action == CmdAddAfter) || (action == CmdSubAfter);

  assign elementIndex = (action == CmdPush) ? currentSize[IndexBits-1:0] :
                        (action == CmdPop)  ? lastIndex : index;
  assign sizeArray    = (action == CmdAlloc) ? allocArray : array;

  // --------------------
  // Decode and checks
  // --------------------
  always_comb begin
    cmdError = ErrNone;
    result   = '0;
    doClear  = 1'b0;
    doAlloc  = 1'b0;
    doFree   = 1'b0;
    doSize   = 1'b0;
    doStore  = 1'b0;
    newSize  = currentSize;
    if (!knownCmd) begin
      cmdError = ErrBadCommand;
    end else if (needsLive && !arrayLive) begin
      cmdError = ErrNotAllocated;
    end else begin
      case (action)
        CmdClear: doClear = 1'b1;
        CmdFree:  doFree  = 1'b1;
        CmdSize:  result  = DataWidth'(currentSize);
        CmdAlloc: begin
          if (canAlloc) begin
            doAlloc = 1'b1;
            doSize  = 1'b1;
            newSize = '0;                         // New array starts empty
            result  = DataWidth'(allocArray);
          end else begin
            cmdError = ErrNoMemory;
          end
        end
        CmdWrite: begin
          doStore = 1'b1;
          result  = in;
          if (!inBounds) begin
            doSize  = 1'b1;
            newSize = indexSize + 1'b1;           // Grow to cover the index
          end
        end
        CmdRead: begin
          if (inBounds) result = readData;
          else cmdError = ErrOutOfBounds;
        end
        CmdPush: begin
          if (currentSize == SizeBits'(ArrayLength)) begin
            cmdError = ErrFull;
          end else begin
            doStore = 1'b1;
            doSize  = 1'b1;
            newSize = currentSize + 1'b1;
          end
        end
        CmdPop: begin
          if (currentSize == '0) begin
            cmdError = ErrEmpty;
          end else begin
            doSize  = 1'b1;
            newSize = currentSize - 1'b1;
            result  = readData;                   // Element at lastIndex
          end
        end
        default: begin                            // Read-modify-write family
          if (inBounds) begin
            doStore = 1'b1;
            result  = isAfter ? readData : newData;
          end else begin
            cmdError = ErrOutOfBounds;
          end
        end
      endcase
    end
  end

  assign accept      = start && (cmdError == ErrNone);
  assign clearEnable = accept && doClear;
  assign allocEnable = accept && doAlloc;
  assign freeEnable  = accept && doFree;
  assign sizeLoad    = accept && doSize;
  assign storeWrite  = accept && doStore;

  // --------------------
  // Result registers
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done  <= 1'b0;
      out   <= '0;
      error <= ErrNone;
    end else begin
      done <= start;
      if (start) begin
        out   <= accept ? result : '0;            // Zero on any error
        error <= cmdError;
      end
    end
  end

  // Fixed one-cycle latency, no result without a command
  assert property (@(posedge clock) disable iff (!resetN) start |=> done);
  assert property (@(posedge clock) disable iff (!resetN) done |-> $past(start));

endmodule

/* heapElementStore.sv */
// Heap element store
// Holds the element memory of all arrays and computes the value that a
// write, push or read-modify-write command puts back
module heapElementStore (
  input  logic                           clock,
  input  logic [heapPkg::ActionBits-1:0] action,
  input  logic [heapPkg::ArrayBits-1:0]  array,
  input  logic [heapPkg::IndexBits-1:0]  elementIndex,
  input  logic [heapPkg::DataWidth-1:0]  in,
  input  logic                           storeWrite,
  output logic [heapPkg::DataWidth-1:0]  readData,
  output logic [heapPkg::DataWidth-1:0]  newData
);
  import heapPkg::*;

  logic [DataWidth-1:0] memory [NumArrays][ArrayLength];   // Arrays in fixed blocks

  assign readData = memory[array][elementIndex];            // Old element

  // --------------------
  // Update arithmetic
  // --------------------
  always_comb begin
    case (action)
      CmdAdd,
      CmdAddAfter: begin
        newData = readData + in;
      end
      CmdSub,
      CmdSubAfter: begin
        newData = readData - in;
      end
      CmdOr: begin
        newData = readData | in;
      end
      CmdXor: begin
        newData = readData ^ in;
      end
      CmdAnd: begin
        newData = readData & in;
      end
      CmdNot: begin
        newData = ~readData;                                // Ignores in
      end
      default: begin
        newData = in;                                       // Write and Push
      end
    endcase
  end

  // --------------------
  // Element memory
  // --------------------
  always_ff @(posedge clock) begin
    if (storeWrite) begin
      memory[array][elementIndex] <= newData;
    end
  end

endmodule

/* heapSizeTable.sv */
// Heap array size table
// One size register per array, loaded on request, with the size of the
// requested array presented combinationally
module heapSizeTable (
  input  logic                          clock,
  input  logic                          resetN,
  input  logic [heapPkg::ArrayBits-1:0] array,
  input  logic                          sizeLoad,
  input  logic [heapPkg::ArrayBits-1:0] sizeArray,
  input  logic [heapPkg::SizeBits-1:0]  newSize,
  output logic [heapPkg::SizeBits-1:0]  currentSize
);
  import heapPkg::*;

  logic [SizeBits-1:0] sizes [NumArrays];         // Current size of each array

  assign currentSize = sizes[array];              // Size of the addressed array

  // --------------------
  // Size registers
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int a = 0; a < NumArrays; a++) begin
        sizes[a] <= '0;                           // Every array starts empty
      end
    end else if (sizeLoad) begin
      sizes[sizeArray] <= newSize;
    end
  end

  // Push, Pop and Write growth are all bounded by the controller checks
  assert property (@(posedge clock) disable iff (!resetN)
    sizeLoad |-> (newSize <= SizeBits'(ArrayLength)));

endmodule

/* heapAllocator.sv */
// Heap array allocator
// Tracks which arrays are live, keeps a LIFO stack of freed arrays and
// hands out never-used array numbers once the stack is empty
module heapAllocator (
  input  logic                          clock,
  input  logic                          resetN,
  input  logic                          clearEnable,
  input  logic                          allocEnable,
  input  logic                          freeEnable,
  input  logic [heapPkg::ArrayBits-1:0] array,
  output logic                          arrayLive,
  output logic                          canAlloc,
  output logic [heapPkg::ArrayBits-1:0] allocArray
);
  import heapPkg::*;

  logic [ArrayBits-1:0] freedStack [NumArrays];   // Freed array numbers
  logic [SizeBits-1:0]  freedTop;                 // Entries on the stack
  logic [SizeBits-1:0]  nextNew;                  // Arrays handed out so far
  logic [NumArrays-1:0] allocated;                // One live bit per array
  logic [ArrayBits-1:0] topIndex;                 // Slot of the newest entry
  logic                 stackEmpty;

  assign topIndex   = freedTop[ArrayBits-1:0] - 1'b1;
  assign stackEmpty = (freedTop == '0);

  assign arrayLive  = allocated[array];
  assign canAlloc   = !stackEmpty || (nextNew < SizeBits'(NumArrays));
  assign allocArray = stackEmpty ? nextNew[ArrayBits-1:0]  // Fresh array
                                 : freedStack[topIndex];   // Most recently freed

  // --------------------
  // Control state
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      freedTop  <= '0;
      nextNew   <= '0;
      allocated <= '0;
    end else if (clearEnable) begin
      freedTop  <= '0;
      nextNew   <= '0;
      allocated <= '0;
    end else if (allocEnable) begin
      if (stackEmpty) begin
        nextNew <= nextNew + 1'b1;
      end else begin
        freedTop <= freedTop - 1'b1;
      end
      allocated[allocArray] <= 1'b1;
    end else if (freeEnable) begin
      freedTop         <= freedTop + 1'b1;
      allocated[array] <= 1'b0;                   // A second free now fails
    end
  end

  // Stack contents, only meaningful below freedTop
  always_ff @(posedge clock) begin
    if (freeEnable && !clearEnable) begin
      freedStack[freedTop[ArrayBits-1:0]] <= array;
    end
  end

  // The controller must never ask for an array when none is left
  assert property (@(posedge clock) disable iff (!resetN) allocEnable |-> canAlloc);

endmodule

/* heapPkg.sv */
// Heap array memory shared definitions
// Sizes, command codes and error codes for the heap unit
package heapPkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int ArrayBits   = 2;                       // Width of an array number
  localparam int IndexBits   = 2;                       // Width of an element index
  localparam int DataWidth   = 12;                      // Element width
  localparam int NumArrays   = 1 << ArrayBits;          // Arrays in the memory
  localparam int ArrayLength = 1 << IndexBits;          // Elements per array
  localparam int SizeBits    = IndexBits + 1;           // Holds 0 to ArrayLength

  // --------------------
  // Command codes
  // --------------------
  localparam int ActionBits = 5;

  localparam logic [ActionBits-1:0] CmdClear    = 5'd1;   // Free every array
  localparam logic [ActionBits-1:0] CmdAlloc    = 5'd2;   // Take an array
  localparam logic [ActionBits-1:0] CmdFree     = 5'd3;   // Return an array
  localparam logic [ActionBits-1:0] CmdWrite    = 5'd4;   // Store, growing the size
  localparam logic [ActionBits-1:0] CmdRead     = 5'd5;
  localparam logic [ActionBits-1:0] CmdSize     = 5'd6;
  localparam logic [ActionBits-1:0] CmdPush     = 5'd7;   // Append at the end
  localparam logic [ActionBits-1:0] CmdPop      = 5'd8;   // Remove from the end
  localparam logic [ActionBits-1:0] CmdAdd      = 5'd9;   // Returns new value
  localparam logic [ActionBits-1:0] CmdAddAfter = 5'd10;  // Returns old value
  localparam logic [ActionBits-1:0] CmdSub      = 5'd11;  // Returns new value
  localparam logic [ActionBits-1:0] CmdSubAfter = 5'd12;  // Returns old value
  localparam logic [ActionBits-1:0] CmdOr       = 5'd13;
  localparam logic [ActionBits-1:0] CmdXor      = 5'd14;
  localparam logic [ActionBits-1:0] CmdAnd      = 5'd15;
  localparam logic [ActionBits-1:0] CmdNot      = 5'd16;  // Bitwise complement
  // CmdNot must stay the highest code, the controller range check relies on it

  // --------------------
  // Error codes
  // --------------------
  localparam int ErrorBits = 3;

  localparam logic [ErrorBits-1:0] ErrNone         = 3'd0;
  localparam logic [ErrorBits-1:0] ErrNotAllocated = 3'd1;  // Array not live
  localparam logic [ErrorBits-1:0] ErrOutOfBounds  = 3'd2;  // Index at or past size
  localparam logic [ErrorBits-1:0] ErrFull         = 3'd3;  // Push on full array
  localparam logic [ErrorBits-1:0] ErrEmpty        = 3'd4;  // Pop on empty array
  localparam logic [ErrorBits-1:0] ErrNoMemory     = 3'd5;  // Nothing left to allocate
  localparam logic [ErrorBits-1:0] ErrBadCommand   = 3'd6;  // Unknown action code

endpackage
